//--- hw/board_cfg_pkg.sv
package board_cfg_pkg;

	typedef logic [31:0] status_t; // Option word from the menu link.
	typedef logic [1:0] buttons_t;
	typedef logic [15:0] audio_sample_t; // Unsigned.

	// Bit positions inside status_t.
	localparam int unsigned STATUS_RESET_BIT = 0;
	localparam int unsigned STATUS_SCAN_LO = 3; // Two-bit scanline field.
	localparam int unsigned STATUS_MENU_RESET_BIT = 9;

	localparam int unsigned BUTTON_RESET_BIT = 1;

	// Same order as the menu entries.
	typedef enum logic [1:0] {
		SCAN_NONE = 2'd0,
		SCAN_25 = 2'd1,
		SCAN_50 = 2'd2,
		SCAN_75 = 2'd3
	} scan_mode_e;

endpackage

//--- hw/video_pkg.sv
package video_pkg;

	typedef logic [5:0] level_t; // Per-colour level at the VGA pins.

	localparam level_t LEVEL_MAX = 6'd63;

	// One bit per colour from the core.
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} core_pixel_t;

	typedef struct packed {
		logic hs;
		logic vs;
	} sync_t;

	typedef struct packed {
		level_t r;
		level_t g;
		level_t b;
		logic hs;
		logic vs;
	} vga_out_t;

endpackage

//--- hw/option_decoder.sv
`timescale 1ns/1ps

module option_decoder #(
	parameter int unsigned RESET_HOLD = 16
) (
	input logic clk_sys,
	input logic reset,
	input board_cfg_pkg::status_t status,
	input board_cfg_pkg::buttons_t buttons,
	input logic scandoubler_disable,
	output board_cfg_pkg::scan_mode_e scan_mode,
	output logic core_reset
);

	localparam int unsigned HOLD_W = (RESET_HOLD > 0) ? $clog2(RESET_HOLD + 1) : 1;
	localparam int unsigned SCAN_W = $bits(board_cfg_pkg::scan_mode_e);

	logic request;
	logic request_q;
	logic [HOLD_W-1:0] hold_cnt;
	logic [SCAN_W-1:0] scan_field;

	assign request = status[board_cfg_pkg::STATUS_RESET_BIT]
		| status[board_cfg_pkg::STATUS_MENU_RESET_BIT]
		| buttons[board_cfg_pkg::BUTTON_RESET_BIT];

	assign scan_field = status[board_cfg_pkg::STATUS_SCAN_LO +: SCAN_W];

	// Board reset looks like a request that has just ended.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			request_q <= 1'b1;
			hold_cnt <= '0;
		end else begin
			request_q <= request;
			if (request_q)
				hold_cnt <= HOLD_W'(RESET_HOLD); // Restart the hold.
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign core_reset = request_q | (hold_cnt != '0);

	always_ff @(posedge clk_sys) begin
		if (reset || scandoubler_disable)
			scan_mode <= board_cfg_pkg::SCAN_NONE; // No dimming without the doubler.
		else
			scan_mode <= board_cfg_pkg::scan_mode_e'(scan_field);
	end

	a_reset_follows_request: assert property (
		@(posedge clk_sys) disable iff (reset) request |=> core_reset
	);

endmodule

//--- hw/line_tracker.sv
`timescale 1ns/1ps

module line_tracker (
	input logic clk_sys,
	input logic reset,
	input video_pkg::core_pixel_t pixel,
	input video_pkg::sync_t sync,
	output logic [2:0] color_bit,
	output logic dim,
	output video_pkg::sync_t sync_q
);

	logic hs_rise;
	logic vs_rise;
	logic odd_line;

	// Edges against the sync seen last cycle.
	assign hs_rise = sync.hs & ~sync_q.hs;
	assign vs_rise = sync.vs & ~sync_q.vs;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			odd_line <= 1'b0;
			sync_q <= '0;
			color_bit <= '0;
		end else begin
			sync_q <= sync;
			color_bit <= {pixel.r, pixel.g, pixel.b}; // Bit 2 is red.
			if (vs_rise)
				odd_line <= 1'b0; // New frame starts even.
			else if (hs_rise)
				odd_line <= ~odd_line;
		end
	end

	// Odd lines get the scanline effect.
	assign dim = odd_line;

	a_even_after_vsync: assert property (
		@(posedge clk_sys) disable iff (reset)
		(sync.vs && !sync_q.vs) |=> !dim
	);

endmodule

//--- hw/channel_shader.sv
`timescale 1ns/1ps

module channel_shader (
	input logic clk_sys,
	input logic reset,
	input logic color_bit,
	input logic dim,
	input board_cfg_pkg::scan_mode_e scan_mode,
	output video_pkg::level_t level
);

	logic [2:0] weight;
	logic [7:0] scaled;
	video_pkg::level_t shade;

	// Full scale times (4 - k), k taken from the mode.
	assign weight = 3'd4 - {1'b0, scan_mode};
	assign scaled = 8'(video_pkg::LEVEL_MAX) * 8'(weight);

	always_comb begin
		if (!color_bit)
			shade = '0;
		else if (dim)
			shade = scaled[7:2]; // SCAN_NONE comes out as 63 here too.
		else
			shade = video_pkg::LEVEL_MAX;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			level <= '0;
		else
			level <= shade;
	end

endmodule

//--- hw/sync_aligner.sv
`timescale 1ns/1ps

module sync_aligner (
	input logic clk_sys,
	input logic reset,
	input video_pkg::level_t level_r,
	input video_pkg::level_t level_g,
	input video_pkg::level_t level_b,
	input video_pkg::sync_t sync_q,
	output video_pkg::vga_out_t vga_out
);

	video_pkg::sync_t sync_d;
	logic blank;

	// Sync one stage later, level with the shaders.
	assign blank = sync_d.hs | sync_d.vs;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sync_d <= '0;
			vga_out <= '0;
		end else begin
			sync_d <= sync_q;
			vga_out.r <= blank ? '0 : level_r;
			vga_out.g <= blank ? '0 : level_g;
			vga_out.b <= blank ? '0 : level_b;
			vga_out.hs <= sync_d.hs;
			vga_out.vs <= sync_d.vs;
		end
	end

	a_blank_in_sync: assert property (
		@(posedge clk_sys) disable iff (reset)
		(sync_q.hs || sync_q.vs) |=> ##1
			(vga_out.r == '0 && vga_out.g == '0 && vga_out.b == '0)
	);

endmodule

//--- hw/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int unsigned AUDIO_BITS = 16
) (
	input logic clk_sys,
	input logic reset,
	input board_cfg_pkg::audio_sample_t sample,
	output logic audio_bit
);

	localparam int unsigned SAMPLE_W = $bits(board_cfg_pkg::audio_sample_t);

	logic [AUDIO_BITS-1:0] acc;
	logic [AUDIO_BITS:0] sum;

	// Upper AUDIO_BITS of the sample feed the modulator.
	assign sum = {1'b0, acc} + {1'b0, sample[SAMPLE_W-1 -: AUDIO_BITS]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc <= sum[AUDIO_BITS-1:0]; // Wraps.
			audio_bit <= sum[AUDIO_BITS]; // Carry is the output density.
		end
	end

endmodule

//--- hw/atmos_board_io.sv
`timescale 1ns/1ps

module atmos_board_io #(
	parameter int unsigned RESET_HOLD = 16,
	parameter int unsigned AUDIO_BITS = 16
) (
	input logic clk_sys,
	input logic reset,
	input board_cfg_pkg::status_t status,
	input board_cfg_pkg::buttons_t buttons,
	input logic scandoubler_disable,
	input video_pkg::core_pixel_t pixel,
	input video_pkg::sync_t sync,
	input board_cfg_pkg::audio_sample_t sample,
	output video_pkg::vga_out_t vga_out,
	output logic core_reset,
	output logic audio_l,
	output logic audio_r
);

	board_cfg_pkg::scan_mode_e scan_mode;
	logic [2:0] color_bit;
	logic dim;
	video_pkg::sync_t sync_q;
	video_pkg::level_t [2:0] level; // Index 2 is red.

	option_decoder #(
		.RESET_HOLD	(RESET_HOLD)
	) option_decoder (
		.clk_sys	(clk_sys),
		.reset	(reset),
		.status	(status),
		.buttons	(buttons),
		.scandoubler_disable	(scandoubler_disable),
		.scan_mode	(scan_mode),
		.core_reset	(core_reset)
	);

	line_tracker line_tracker (
		.clk_sys	(clk_sys),
		.reset	(reset),
		.pixel	(pixel),
		.sync	(sync),
		.color_bit	(color_bit),
		.dim	(dim),
		.sync_q	(sync_q)
	);

	for (genvar ch = 0; ch < 3; ch++) begin : gen_channel
		channel_shader channel_shader (
			.clk_sys	(clk_sys),
			.reset	(reset),
			.color_bit	(color_bit[ch]),
			.dim	(dim),
			.scan_mode	(scan_mode),
			.level	(level[ch])
		);
	end

	sync_aligner sync_aligner (
		.clk_sys	(clk_sys),
		.reset	(reset),
		.level_r	(level[2]),
		.level_g	(level[1]),
		.level_b	(level[0]),
		.sync_q	(sync_q),
		.vga_out	(vga_out)
	);

	sigma_delta_dac #(
		.AUDIO_BITS	(AUDIO_BITS)
	) sigma_delta_dac (
		.clk_sys	(clk_sys),
		.reset	(reset),
		.sample	(sample),
		.audio_bit	(audio_l)
	);

	assign audio_r = audio_l; // Mono on both pins.

endmodule

//--- dv/tb_atmos_board_io.sv
`timescale 1ns/1ps

module tb_atmos_board_io;

	localparam int unsigned RESET_HOLD = 16;
	localparam int unsigned AUDIO_BITS = 16;
	localparam int unsigned DAC_CYCLES = 65536;
	localparam int unsigned LINE_CYCLES = 12;
	localparam int unsigned FRAME_LINES = 8;
	// Three DAC runs, random video, eight shaded frames, four reset holds, margin.
	localparam int unsigned TIMEOUT_CYCLES = 3 * (DAC_CYCLES + 8) + 400
		+ 8 * (2 + FRAME_LINES * LINE_CYCLES) + 4 * (RESET_HOLD + 8) + 1000;

	logic clk_sys = 1'b0;
	logic reset;
	board_cfg_pkg::status_t status;
	board_cfg_pkg::buttons_t buttons;
	logic scandoubler_disable;
	video_pkg::core_pixel_t pixel;
	video_pkg::sync_t sync;
	board_cfg_pkg::audio_sample_t sample;
	video_pkg::vga_out_t vga_out;
	logic core_reset;
	logic audio_l;
	logic audio_r;

	string test_name = "reset";
	video_pkg::vga_out_t expected_q[$]; // Three pixels in flight.
	logic odd_line_model = 1'b0;
	video_pkg::sync_t sync_prev = '0;
	int unsigned since_request = 0;
	int unsigned cycle_count = 0;

	always #50 clk_sys = ~clk_sys;

	atmos_board_io #(
		.RESET_HOLD	(RESET_HOLD),
		.AUDIO_BITS	(AUDIO_BITS)
	) dut_i (
		.clk_sys	(clk_sys),
		.reset	(reset),
		.status	(status),
		.buttons	(buttons),
		.scandoubler_disable	(scandoubler_disable),
		.pixel	(pixel),
		.sync	(sync),
		.sample	(sample),
		.vga_out	(vga_out),
		.core_reset	(core_reset),
		.audio_l	(audio_l),
		.audio_r	(audio_r)
	);

	function automatic video_pkg::level_t shaded_level(logic lit, logic odd,
		board_cfg_pkg::scan_mode_e mode);
		int k;
		k = mode; // Dimming step, one quarter each.
		if (!lit)
			return '0;
		if (!odd || mode == board_cfg_pkg::SCAN_NONE)
			return 6'd63;
		return video_pkg::level_t'(63 * (4 - k) / 4);
	endfunction

	function automatic video_pkg::vga_out_t vga_expected(video_pkg::core_pixel_t px,
		video_pkg::sync_t sy, logic odd, board_cfg_pkg::scan_mode_e mode);
		video_pkg::vga_out_t v;
		v.r = shaded_level(px.r, odd, mode);
		v.g = shaded_level(px.g, odd, mode);
		v.b = shaded_level(px.b, odd, mode);
		v.hs = sy.hs;
		v.vs = sy.vs;
		if (sy.hs || sy.vs) begin
			v.r = '0; // Blanked in sync.
			v.g = '0;
			v.b = '0;
		end
		return v;
	endfunction

	// Edges counted from the last one that saw a request.
	function automatic logic hold_expected(int unsigned edges_since);
		return edges_since <= RESET_HOLD;
	endfunction

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_equal(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual));
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic drive_video(logic [2:0] rgb, logic hs, logic vs);
		@(negedge clk_sys);
		pixel = video_pkg::core_pixel_t'(rgb);
		sync.hs = hs;
		sync.vs = vs;
	endtask

	task automatic drive_frame();
		repeat (2) drive_video(3'($urandom), 1'b0, 1'b1);
		for (int line = 0; line < FRAME_LINES; line++) begin
			repeat (2) drive_video(3'($urandom), 1'b1, 1'b0);
			repeat (LINE_CYCLES - 2) drive_video(3'($urandom), 1'b0, 1'b0);
		end
	endtask

	// Counts cycles with core_reset still high.
	task automatic count_hold(output int unsigned highs);
		highs = 0;
		do begin
			@(negedge clk_sys);
			if (core_reset)
				highs++;
		end while (core_reset);
	endtask

	always @(posedge clk_sys) begin : model_update
		logic request;
		board_cfg_pkg::scan_mode_e mode;
		request = reset | status[board_cfg_pkg::STATUS_RESET_BIT]
			| status[board_cfg_pkg::STATUS_MENU_RESET_BIT]
			| buttons[board_cfg_pkg::BUTTON_RESET_BIT];
		if (request)
			since_request = 0;
		else if (since_request < 1000)
			since_request++;
		mode = board_cfg_pkg::scan_mode_e'(status[board_cfg_pkg::STATUS_SCAN_LO +: 2]);
		if (scandoubler_disable)
			mode = board_cfg_pkg::SCAN_NONE;
		if (reset) begin
			odd_line_model = 1'b0;
			sync_prev = '0;
			foreach (expected_q[i])
				expected_q[i] = '0; // Pipeline flushed.
			expected_q.push_back('0);
		end else begin
			if (sync.vs && !sync_prev.vs)
				odd_line_model = 1'b0;
			else if (sync.hs && !sync_prev.hs)
				odd_line_model = ~odd_line_model;
			sync_prev = sync;
			expected_q.push_back(vga_expected(pixel, sync, odd_line_model, mode));
		end
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run("Timeout: the run went past its cycle limit without finishing.");
	end

	always @(negedge clk_sys) begin : compare_outputs
		video_pkg::vga_out_t expected_vga;
		if (expected_q.size() == 3) begin
			expected_vga = expected_q.pop_front();
			check_equal({test_name, " vga_out"}, expected_vga, vga_out);
			check_equal({test_name, " core_reset"}, hold_expected(since_request), core_reset);
			check_equal({test_name, " audio_r"}, audio_l, audio_r);
		end
	end

	initial begin
		int unsigned highs;
		board_cfg_pkg::audio_sample_t dac_values[3];
		void'($urandom(32'h4fed_2a6c));
		reset = 1'b1;
		status = '0;
		buttons = '0;
		scandoubler_disable = 1'b0;
		pixel = '0;
		sync = '0;
		sample = '0;

		apply_reset();
		check_equal("reset vga_out", 0, vga_out);
		check_equal("reset audio", 0, audio_l);
		check_equal("reset core_reset", 1, core_reset);
		count_hold(highs);
		check_equal("reset hold", RESET_HOLD, highs);

		test_name = "random video";
		repeat (400)
			drive_video(3'($urandom), ($urandom % 4) == 0, ($urandom % 8) == 0);

		for (int m = 1; m < 5; m++) begin
			test_name = (m < 4) ? $sformatf("scanline mode %0d", m) : "scandoubler disabled";
			status = board_cfg_pkg::status_t'(((m < 4) ? m : 3) << board_cfg_pkg::STATUS_SCAN_LO);
			scandoubler_disable = (m == 4);
			repeat (2) drive_frame();
		end
		status = '0;
		scandoubler_disable = 1'b0;

		for (int p = 0; p < 3; p++) begin
			test_name = (p == 0) ? "status bit 0" : (p == 1) ? "status bit 9" : "button 1";
			@(negedge clk_sys);
			check_equal(test_name, 0, core_reset);
			case (p)
				0: status[board_cfg_pkg::STATUS_RESET_BIT] = 1'b1;
				1: status[board_cfg_pkg::STATUS_MENU_RESET_BIT] = 1'b1;
				default: buttons[board_cfg_pkg::BUTTON_RESET_BIT] = 1'b1;
			endcase
			@(negedge clk_sys);
			check_equal(test_name, 1, core_reset);
			repeat (2) @(negedge clk_sys);
			status = '0;
			buttons = '0;
			count_hold(highs);
			check_equal(test_name, RESET_HOLD, highs);
		end

		dac_values[0] = 16'h0000;
		dac_values[1] = 16'h4000;
		dac_values[2] = 16'($urandom);
		foreach (dac_values[i]) begin
			test_name = $sformatf("dac 0x%04h", dac_values[i]);
			sample = dac_values[i];
			apply_reset();
			highs = 0;
			repeat (DAC_CYCLES) begin
				@(negedge clk_sys);
				if (audio_l)
					highs++;
			end
			check_equal(test_name, dac_values[i], highs);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- verilog.f
hw/board_cfg_pkg.sv
hw/video_pkg.sv
hw/option_decoder.sv
hw/line_tracker.sv
hw/channel_shader.sv
hw/sync_aligner.sv
hw/sigma_delta_dac.sv
hw/atmos_board_io.sv
dv/tb_atmos_board_io.sv

//--- Bender.yml
package:
  name: atmos_board_io

sources:
  - files:
      - hw/board_cfg_pkg.sv
      - hw/video_pkg.sv
      - hw/option_decoder.sv
      - hw/line_tracker.sv
      - hw/channel_shader.sv
      - hw/sync_aligner.sv
      - hw/sigma_delta_dac.sv
      - hw/atmos_board_io.sv
  - target: test
    files:
      - dv/tb_atmos_board_io.sv
